// ==== hw/lcd_consts.svh ====
`ifndef LCD_CONSTS_SVH
`define LCD_CONSTS_SVH

`define GRID_W        16
`define GRID_H        12
`define CELL_PX       20
`define PANEL_W       320
`define PANEL_H       240

`define INIT_WAIT     64   // Short panel wait for simulation.

`define COLOR_EMPTY   16'he580
`define COLOR_HEAD    16'hf0f8
`define COLOR_BODY    16'hf800
`define COLOR_APPLE   16'h00f8
`define COLOR_BORDER  16'h0000

`define CMD_SWRESET   8'h01
`define CMD_DISPOFF   8'h28
`define CMD_PIXFMT    8'h3a
`define PIXFMT_16     8'h55   // RGB565.
`define CMD_SLPOUT    8'h11
`define CMD_DISPON    8'h29
`define CMD_COLSET    8'h2a
`define CMD_PAGESET   8'h2b
`define CMD_MEMWR     8'h2c

`endif

// ==== hw/lcd_pkg.sv ====
`default_nettype none

package lcd_pkg;

    typedef enum logic [2:0] {
        OBJ_EMPTY  = 3'd0,
        OBJ_HEAD   = 3'd1,
        OBJ_BODY   = 3'd2,
        OBJ_APPLE  = 3'd3,
        OBJ_BORDER = 3'd4
    } obj_code_t;

    typedef struct packed {
        logic border;
        logic head;
        logic body;
        logic apple;
    } obj_flags_t;

    typedef struct packed {
        logic [3:0] x;   // Column.
        logic [3:0] y;   // Row.
    } scan_pos_t;

    typedef struct packed {
        logic [7:0] d;
        logic       dcx;   // 0 command, 1 data.
        logic       wr;
    } lcd_bus_t;

    typedef enum logic [1:0] {
        ST_INIT  = 2'd0,
        ST_SCAN  = 2'd1,
        ST_PAINT = 2'd2,
        ST_OVER  = 2'd3
    } screen_state_t;

endpackage

`default_nettype wire

// ==== hw/button_sync.sv ====
`default_nettype none

module button_sync (
    input  logic clk,
    input  logic nrst,
    input  logic btn,
    output logic press
);

    logic [1:0] sync_q;
    logic       last_q;

    always_ff @(posedge clk, negedge nrst) begin
        if (!nrst) begin
            sync_q <= 2'b00;
            last_q <= 1'b0;
        end else begin
            sync_q <= {sync_q[0], btn};
            last_q <= sync_q[1];   // Previous synced level.
        end
    end

    assign press = sync_q[1] & ~last_q;

endmodule

`default_nettype wire

// ==== hw/screen_ctrl.sv ====
`default_nettype none

module screen_ctrl import lcd_pkg::*; (
    input  logic clk,
    input  logic nrst,
    input  logic game_over,
    input  logic mode_press,
    input  logic diff,
    input  logic done,
    output logic scan_en,
    output logic clear,
    output logic init_req,
    output logic paint_req
);

    screen_state_t state;
    screen_state_t state_next;

    always_ff @(posedge clk, negedge nrst) begin
        if (!nrst) begin
            state <= ST_INIT;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        scan_en    = 1'b0;
        clear      = 1'b0;
        init_req   = 1'b0;
        paint_req  = 1'b0;
        state_next = state;
        case (state)
            ST_INIT: begin
                init_req   = 1'b1;
                // Panel is ready, so restart the game on a clean shadow map.
                clear      = done;
                state_next = done ? ST_SCAN : ST_INIT;
            end
            ST_SCAN: begin
                scan_en    = ~(diff | game_over);
                state_next = diff ? ST_PAINT : (game_over ? ST_OVER : ST_SCAN);
            end
            ST_PAINT: begin
                paint_req  = ~game_over;   // Dropping it aborts the paint.
                state_next = done ? ST_SCAN : (game_over ? ST_OVER : ST_PAINT);
            end
            ST_OVER: begin
                clear      = ~mode_press;
                state_next = mode_press ? ST_INIT : ST_OVER;
            end
            default: begin
                state_next = ST_INIT;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== hw/frame_tracker.sv ====
`default_nettype none

`include "lcd_consts.svh"

module frame_tracker import lcd_pkg::*; (
    input  logic       clk,
    input  logic       nrst,
    input  logic       scan_en,
    input  logic       clear,
    input  obj_flags_t flags,
    output scan_pos_t  pos,
    output obj_code_t  cell_obj,
    output logic       diff
);

    obj_code_t shadow [`GRID_H][`GRID_W];   // Last drawn object per cell.
    logic      last_col;
    logic      last_row;

    // Border wins over head, head over body, body over apple.
    always_comb begin
        if (flags.border) begin
            cell_obj = OBJ_BORDER;
        end else if (flags.head) begin
            cell_obj = OBJ_HEAD;
        end else if (flags.body) begin
            cell_obj = OBJ_BODY;
        end else if (flags.apple) begin
            cell_obj = OBJ_APPLE;
        end else begin
            cell_obj = OBJ_EMPTY;
        end
    end

    assign diff     = shadow[pos.y][pos.x] != cell_obj;
    assign last_col = pos.x == 4'(`GRID_W - 1);
    assign last_row = pos.y == 4'(`GRID_H - 1);

    always_ff @(posedge clk, negedge nrst) begin
        if (!nrst) begin
            pos <= '0;
        end else if (clear) begin
            pos <= '0;
        end else if (scan_en) begin
            if (last_col) begin
                pos.x <= 4'd0;
                pos.y <= last_row ? 4'd0 : pos.y + 4'd1;   // Row-major wrap.
            end else begin
                pos.x <= pos.x + 4'd1;
            end
        end
    end

    always_ff @(posedge clk, negedge nrst) begin
        if (!nrst) begin
            for (int r = 0; r < `GRID_H; r++) begin
                for (int c = 0; c < `GRID_W; c++) begin
                    shadow[r][c] <= OBJ_EMPTY;
                end
            end
        end else if (clear) begin
            for (int r = 0; r < `GRID_H; r++) begin
                for (int c = 0; c < `GRID_W; c++) begin
                    shadow[r][c] <= OBJ_EMPTY;
                end
            end
        end else begin
            shadow[pos.y][pos.x] <= cell_obj;
        end
    end

endmodule

`default_nettype wire

// ==== hw/cell_painter.sv ====
`default_nettype none

`include "lcd_consts.svh"

module cell_painter import lcd_pkg::*; (
    input  logic      clk,
    input  logic      nrst,
    input  logic      init_req,
    input  logic      paint_req,
    input  scan_pos_t pos,
    input  obj_code_t cell_obj,
    output logic      done,
    output lcd_bus_t  lcd
);

    localparam logic [4:0] IDX_SWRESET = 5'd0;
    localparam logic [4:0] IDX_SLPOUT  = 5'd4;
    localparam logic [4:0] IDX_COLSET  = 5'd6;   // Cell paints start here.
    localparam logic [4:0] IDX_PIX_HI  = 5'd17;
    localparam logic [4:0] IDX_PIX_LO  = 5'd18;
    localparam logic [4:0] IDX_END     = 5'd19;
    localparam int         WAIT_W      = $clog2(`INIT_WAIT + 1);

    logic              active;
    logic              is_init;
    logic              phase;      // Set while the next cycle is the strobe.
    logic [4:0]        idx;
    logic [WAIT_W-1:0] wait_cnt;
    logic [16:0]       pix_cnt;
    logic [16:0]       pix_last;
    logic              sel_init;
    logic              req;
    logic [4:0]        cur_idx;
    logic [15:0]       col_lo, col_hi, page_lo, page_hi, color;
    logic [7:0]        cur_d;
    logic              cur_dcx;

    assign sel_init = active ? is_init : init_req;
    assign req      = is_init ? init_req : paint_req;
    assign cur_idx  = active ? idx : (init_req ? IDX_SWRESET : IDX_COLSET);

    always_comb begin
        if (sel_init) begin
            col_lo   = 16'd0;
            col_hi   = 16'(`PANEL_W - 1);
            page_lo  = 16'd0;
            page_hi  = 16'(`PANEL_H - 1);
            pix_last = 17'(`PANEL_W * `PANEL_H - 1);
            color    = `COLOR_EMPTY;
        end else begin
            col_lo   = 16'(pos.x) * 16'(`CELL_PX);
            col_hi   = col_lo + 16'(`CELL_PX - 1);
            page_lo  = 16'(pos.y) * 16'(`CELL_PX);
            page_hi  = page_lo + 16'(`CELL_PX - 1);
            pix_last = 17'(`CELL_PX * `CELL_PX - 1);
            case (cell_obj)
                OBJ_HEAD:   color = `COLOR_HEAD;
                OBJ_BODY:   color = `COLOR_BODY;
                OBJ_APPLE:  color = `COLOR_APPLE;
                OBJ_BORDER: color = `COLOR_BORDER;
                default:    color = `COLOR_EMPTY;
            endcase
        end
    end

    always_comb begin
        cur_dcx = 1'b1;
        case (cur_idx)
            5'd0:    {cur_d, cur_dcx} = {`CMD_SWRESET, 1'b0};
            5'd1:    {cur_d, cur_dcx} = {`CMD_DISPOFF, 1'b0};
            5'd2:    {cur_d, cur_dcx} = {`CMD_PIXFMT, 1'b0};
            5'd3:    cur_d = `PIXFMT_16;
            5'd4:    {cur_d, cur_dcx} = {`CMD_SLPOUT, 1'b0};
            5'd5:    {cur_d, cur_dcx} = {`CMD_DISPON, 1'b0};
            5'd6:    {cur_d, cur_dcx} = {`CMD_COLSET, 1'b0};
            5'd7:    cur_d = col_lo[15:8];
            5'd8:    cur_d = col_lo[7:0];
            5'd9:    cur_d = col_hi[15:8];
            5'd10:   cur_d = col_hi[7:0];
            5'd11:   {cur_d, cur_dcx} = {`CMD_PAGESET, 1'b0};
            5'd12:   cur_d = page_lo[15:8];
            5'd13:   cur_d = page_lo[7:0];
            5'd14:   cur_d = page_hi[15:8];
            5'd15:   cur_d = page_hi[7:0];
            5'd16:   {cur_d, cur_dcx} = {`CMD_MEMWR, 1'b0};
            5'd17:   cur_d = color[15:8];
            5'd18:   cur_d = color[7:0];
            default: {cur_d, cur_dcx} = {8'h00, 1'b0};
        endcase
    end

    always_ff @(posedge clk, negedge nrst) begin
        if (!nrst) begin
            active   <= 1'b0;
            is_init  <= 1'b0;
            phase    <= 1'b0;
            idx      <= '0;
            wait_cnt <= '0;
            pix_cnt  <= '0;
            done     <= 1'b0;
            lcd      <= '0;
        end else begin
            done   <= 1'b0;
            lcd.wr <= 1'b0;
            if (!active) begin
                if ((init_req || paint_req) && !done) begin   // Request still up after done.
                    active  <= 1'b1;
                    is_init <= init_req;
                    idx     <= cur_idx;
                    pix_cnt <= '0;
                    phase   <= 1'b1;
                    lcd.d   <= cur_d;
                    lcd.dcx <= cur_dcx;
                end
            end else if (!req) begin
                active   <= 1'b0;
                phase    <= 1'b0;
                wait_cnt <= '0;
            end else if (phase) begin
                lcd.wr <= 1'b1;
                phase  <= 1'b0;
                case (idx)
                    IDX_SWRESET, IDX_SLPOUT: begin
                        wait_cnt <= WAIT_W'(`INIT_WAIT);
                        idx      <= idx + 5'd1;
                    end
                    IDX_PIX_LO: begin
                        if (pix_cnt == pix_last) begin
                            idx <= IDX_END;
                        end else begin
                            pix_cnt <= pix_cnt + 17'd1;
                            idx     <= IDX_PIX_HI;
                        end
                    end
                    default: idx <= idx + 5'd1;
                endcase
            end else if (wait_cnt != '0) begin
                wait_cnt <= wait_cnt - 1'b1;
            end else if (idx == IDX_END) begin
                active <= 1'b0;
                done   <= 1'b1;
            end else begin
                lcd.d   <= cur_d;   // Setup cycle.
                lcd.dcx <= cur_dcx;
                phase   <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/image_generator.sv ====
`default_nettype none

module image_generator import lcd_pkg::*; (
    input  logic       clk,
    input  logic       nrst,
    input  obj_flags_t flags,
    input  logic       game_over,
    input  logic       mode_btn,
    output scan_pos_t  pos,
    output logic       game_reset,
    output lcd_bus_t   lcd
);

    logic      mode_press;
    logic      scan_en;
    logic      clear;
    logic      diff;
    logic      init_req;
    logic      paint_req;
    logic      done;
    obj_code_t cell_obj;

    assign game_reset = clear;

    button_sync sync_i (
        .clk   (clk),
        .nrst  (nrst),
        .btn   (mode_btn),
        .press (mode_press)
    );

    screen_ctrl ctrl_i (
        .clk        (clk),
        .nrst       (nrst),
        .game_over  (game_over),
        .mode_press (mode_press),
        .diff       (diff),
        .done       (done),
        .scan_en    (scan_en),
        .clear      (clear),
        .init_req   (init_req),
        .paint_req  (paint_req)
    );

    frame_tracker tracker_i (
        .clk      (clk),
        .nrst     (nrst),
        .scan_en  (scan_en),
        .clear    (clear),
        .flags    (flags),
        .pos      (pos),
        .cell_obj (cell_obj),
        .diff     (diff)
    );

    cell_painter painter_i (
        .clk       (clk),
        .nrst      (nrst),
        .init_req  (init_req),
        .paint_req (paint_req),
        .pos       (pos),
        .cell_obj  (cell_obj),
        .done      (done),
        .lcd       (lcd)
    );

endmodule

`default_nettype wire

// ==== bench/image_generator_assert.sv ====
`default_nettype none

`include "lcd_consts.svh"

module image_generator_assert import lcd_pkg::*; (
    input logic      clk,
    input logic      nrst,
    input lcd_bus_t  lcd,
    input scan_pos_t pos,
    input logic      game_reset,
    input logic      done
);

    timeunit 1ns;
    timeprecision 1ps;

    int fails = 0;   // Read by the testbench.

    wr_single: assert property (@(posedge clk) disable iff (!nrst) lcd.wr |=> !lcd.wr)
        else begin
            fails++;
            $error("wr high in two consecutive cycles");
        end

    bus_stable: assert property (@(posedge clk) disable iff (!nrst)
        $rose(lcd.wr) |-> $stable({lcd.d, lcd.dcx}))
        else begin
            fails++;
            $error("d or dcx changed between setup and strobe");
        end

    done_pulse: assert property (@(posedge clk) disable iff (!nrst) done |=> !done)
        else begin
            fails++;
            $error("done longer than one cycle");
        end

    pos_in_grid: assert property (@(posedge clk) disable iff (!nrst)
        pos.x < `GRID_W && pos.y < `GRID_H)
        else begin
            fails++;
            $error("scan position outside the grid");
        end

    quiet_in_reset: assert property (@(posedge clk) disable iff (!nrst)
        game_reset |-> !lcd.wr)
        else begin
            fails++;
            $error("wr strobe while game_reset is high");
        end

endmodule

bind image_generator image_generator_assert assert_i (
    .clk        (clk),
    .nrst       (nrst),
    .lcd        (lcd),
    .pos        (pos),
    .game_reset (game_reset),
    .done       (done)
);

`default_nettype wire

// ==== bench/image_generator_tb.sv ====
`default_nettype none

`include "lcd_consts.svh"

module image_generator_tb import lcd_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int CELLS        = `GRID_W * `GRID_H;
    localparam int PAINT_CYCLES = 2 * (11 + 2 * `CELL_PX * `CELL_PX) + 1;
    localparam int INIT_CYCLES  = 2 * (17 + 2 * `PANEL_W * `PANEL_H) + 2 * `INIT_WAIT + 1;
    // Two start-ups, four full repaints and some slack.
    localparam int TIMEOUT_CYCLES = 2 * INIT_CYCLES + 4 * CELLS * (PAINT_CYCLES + 2) + 100000;

    // Bus bytes as {dcx, d}.
    localparam logic [8:0] STARTUP [20] = '{
        {1'b0, `CMD_SWRESET}, {1'b0, `CMD_DISPOFF}, {1'b0, `CMD_PIXFMT}, {1'b1, `PIXFMT_16},
        {1'b0, `CMD_SLPOUT}, {1'b0, `CMD_DISPON}, {1'b0, `CMD_COLSET},
        9'h100, 9'h100, 9'h101, 9'h13f,   // Columns 0 to 319.
        {1'b0, `CMD_PAGESET}, 9'h100, 9'h100, 9'h100, 9'h1ef,
        {1'b0, `CMD_MEMWR}, 9'h1e5, 9'h180, 9'h1e5
    };

    logic       clk;
    logic       nrst;
    obj_flags_t flags;
    logic       game_over;
    logic       mode_btn;
    scan_pos_t  pos;
    logic       game_reset;
    lcd_bus_t   lcd;

    logic [31:0] lfsr;
    obj_flags_t  map [`GRID_H][`GRID_W];
    logic [15:0] drawn [`GRID_H][`GRID_W];   // Colour the panel should show.
    logic        pending [`GRID_H][`GRID_W];
    logic [15:0] pix [`PANEL_W * `PANEL_H];
    logic [8:0]  log_bus [20];
    int          log_n;
    logic [7:0]  cmd;
    logic [31:0] col_args;
    logic [31:0] page_args;
    logic [7:0]  hi;
    logic        hi_ready;
    int          cur_x;
    int          cur_y;
    int          colsets;
    int          expect_paints;
    int          cycles;

    image_generator image_generator_i (
        .clk        (clk),
        .nrst       (nrst),
        .flags      (flags),
        .game_over  (game_over),
        .mode_btn   (mode_btn),
        .pos        (pos),
        .game_reset (game_reset),
        .lcd        (lcd)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [3:0] rand_bits(input int n);
        logic [3:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[2:0], lfsr[0]};
            lfsr = lfsr[0] ? (lfsr >> 1) ^ 32'h80200003 : lfsr >> 1;
        end
        return v;
    endfunction

    function automatic logic [15:0] color_of(input obj_flags_t f);
        if (f.border) return `COLOR_BORDER;
        if (f.head) return `COLOR_HEAD;
        if (f.body) return `COLOR_BODY;
        if (f.apple) return `COLOR_APPLE;
        return `COLOR_EMPTY;
    endfunction

    // Row-major successor of a grid cell.
    function automatic scan_pos_t next_cell(input scan_pos_t p);
        int        n;
        scan_pos_t q;
        n   = (int'(p.y) * `GRID_W + int'(p.x) + 1) % CELLS;
        q.x = 4'(n % `GRID_W);
        q.y = 4'(n / `GRID_W);
        return q;
    endfunction

    task automatic check(input string name, input int expected, input int actual);
        if (expected != actual) begin
            $display("Mismatch in %s: expected %0h, actual %0h", name, expected, actual);
            $display("RESULT: FAIL");
            $fatal(1, "Check failed");
        end
    endtask

    task automatic open_window();
        int cx;
        int cy;
        cur_x    = int'(col_args[31:16]);
        cur_y    = int'(page_args[31:16]);
        hi_ready = 1'b0;
        if (col_args[15:0] != 16'(`PANEL_W - 1) || page_args[15:0] != 16'(`PANEL_H - 1)) begin
            cx = cur_x / `CELL_PX;
            cy = cur_y / `CELL_PX;
            check("window column start", cx * `CELL_PX, cur_x);
            check("window page start", cy * `CELL_PX, cur_y);
            check("window column end", cur_x + `CELL_PX - 1, int'(col_args[15:0]));
            check("window page end", cur_y + `CELL_PX - 1, int'(page_args[15:0]));
            check("window on changed cell", 1, int'(pending[cy][cx]));
            pending[cy][cx] = 1'b0;
        end
    endtask

    task automatic take_byte(input logic dcx, input logic [7:0] d);
        if (log_n < 20) begin
            log_bus[log_n] = {dcx, d};
            log_n++;
        end
        if (!dcx) begin
            cmd = d;
            if (d == `CMD_COLSET) colsets++;
            if (d == `CMD_MEMWR) open_window();
        end else if (cmd == `CMD_COLSET) begin
            col_args = {col_args[23:0], d};
        end else if (cmd == `CMD_PAGESET) begin
            page_args = {page_args[23:0], d};
        end else if (cmd == `CMD_MEMWR && !hi_ready) begin
            hi       = d;   // High byte first.
            hi_ready = 1'b1;
        end else if (cmd == `CMD_MEMWR) begin
            pix[cur_y * `PANEL_W + cur_x] = {hi, d};
            hi_ready = 1'b0;
            if (cur_x == int'(col_args[15:0])) begin
                cur_x = int'(col_args[31:16]);
                cur_y++;
            end else begin
                cur_x++;
            end
        end
    endtask

    // Game answers the scan position; panel latches each strobed byte.
    always @(negedge clk) begin
        flags <= map[pos.y][pos.x];
        if (lcd.wr) begin
            take_byte(lcd.dcx, lcd.d);
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > TIMEOUT_CYCLES) begin
            $display("Timeout: the run hung for %0d cycles", TIMEOUT_CYCLES);
            $display("RESULT: FAIL");
            $fatal(1, "Simulation hung");
        end else if (image_generator_i.assert_i.fails != 0) begin
            $display("A bus or control assertion failed");
            $display("RESULT: FAIL");
            $fatal(1, "Assertion failed");
        end
    end

    task automatic clear_drawn();
        for (int y = 0; y < `GRID_H; y++) begin
            for (int x = 0; x < `GRID_W; x++) begin
                drawn[y][x]   = `COLOR_EMPTY;
                pending[y][x] = 1'b0;
            end
        end
    endtask

    task automatic apply_map();
        logic [15:0] c;
        colsets       = 0;
        expect_paints = 0;
        for (int y = 0; y < `GRID_H; y++) begin
            for (int x = 0; x < `GRID_W; x++) begin
                c = color_of(map[y][x]);
                if (c != drawn[y][x]) begin
                    drawn[y][x]   = c;
                    pending[y][x] = 1'b1;
                    expect_paints++;
                end
            end
        end
    endtask

    // Returns once a whole scan round passes without a paint.
    task automatic settle();
        int        steps;
        int        seen;
        scan_pos_t last;
        steps = 0;
        seen  = colsets;
        last  = pos;
        while (steps < CELLS) begin
            @(negedge clk);
            if (colsets != seen) begin
                seen  = colsets;
                steps = 0;
            end else if (pos != last) begin
                check("scan order", int'(next_cell(last)), int'(pos));
                steps++;
            end
            last = pos;
        end
    endtask

    task automatic wait_init_done();
        @(negedge clk);
        while (game_reset) @(negedge clk);
        while (!game_reset) @(negedge clk);
    endtask

    task automatic check_startup();
        for (int i = 0; i < 20; i++) begin
            check("start-up byte", int'(STARTUP[i]), int'(log_bus[i]));
        end
    endtask

    task automatic check_screen(input string name);
        for (int y = 0; y < `PANEL_H; y++) begin
            for (int x = 0; x < `PANEL_W; x++) begin
                check(name, int'(color_of(map[y / `CELL_PX][x / `CELL_PX])),
                      int'(pix[y * `PANEL_W + x]));
            end
        end
    endtask

    task automatic check_round(input string name);
        check({name, " windows"}, expect_paints, colsets);
        check_screen(name);
    endtask

    initial begin
        int x;
        int y;
        lfsr      = 32'hef70;
        nrst      = 1'b0;
        flags     = '0;
        game_over = 1'b0;
        mode_btn  = 1'b0;
        log_n     = 0;
        cmd       = '0;
        col_args  = '0;
        page_args = '0;
        hi_ready  = 1'b0;
        colsets   = 0;
        cycles    = 0;
        for (int r = 0; r < `GRID_H; r++) begin
            for (int c = 0; c < `GRID_W; c++) begin
                map[r][c] = '0;
            end
        end
        clear_drawn();
        repeat (4) @(negedge clk);
        nrst = 1'b1;

        wait_init_done();
        apply_map();
        check_startup();
        check_screen("start-up clear");
        settle();

        @(posedge clk);
        for (int r = 0; r < `GRID_H; r++) begin
            for (int c = 0; c < `GRID_W; c++) begin
                map[r][c] = rand_bits(4);
            end
        end
        apply_map();
        settle();
        check_round("full map");

        repeat (4) begin
            @(posedge clk);
            repeat (int'(rand_bits(2)) + 1) begin
                x = int'(rand_bits(4));
                y = int'(rand_bits(4)) % `GRID_H;
                map[y][x] = rand_bits(4);
            end
            apply_map();
            settle();
            check_round("redraw");
        end

        // Game over arrives while a cell paint is under way.
        @(posedge clk);
        x = int'(rand_bits(4));
        y = int'(rand_bits(4)) % `GRID_H;
        map[y][x] = obj_flags_t'(~map[y][x]);
        apply_map();
        while (colsets == 0) @(negedge clk);
        game_over = 1'b1;
        @(negedge clk);
        repeat (200) begin
            @(negedge clk);
            check("game over wr", 0, int'(lcd.wr));
            check("game over reset", 1, int'(game_reset));
        end
        game_over = 1'b0;
        mode_btn  = 1'b1;
        log_n     = 0;
        clear_drawn();
        repeat (4) @(negedge clk);
        mode_btn = 1'b0;
        wait_init_done();
        apply_map();
        check_startup();
        settle();
        check_round("restart");

        $display("RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== all.f ====
+incdir+hw
hw/lcd_pkg.sv
hw/button_sync.sv
hw/screen_ctrl.sv
hw/frame_tracker.sv
hw/cell_painter.sv
hw/image_generator.sv
bench/image_generator_assert.sv
bench/image_generator_tb.sv

// ==== Makefile ====
TOP = image_generator_tb

all: run

compile:
	verilator --binary -j 0 -sv -Wno-fatal -f all.f --top-module $(TOP) -Mdir obj_dir -o sim

run: compile
	./obj_dir/sim > sim.log 2>&1; cat sim.log
	grep -q "RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all compile run clean
